//--- hw/csr_pkg.sv
package csr_pkg;

    localparam int XLEN      = 32;
    localparam int CSR_NUM_W = 14;
    localparam int SUBCODE_W = 9;
    localparam int HWI_N     = 8;

    localparam logic [CSR_NUM_W-1:0] ADDR_CRMD   = 14'h0;
    localparam logic [CSR_NUM_W-1:0] ADDR_PRMD   = 14'h1;
    localparam logic [CSR_NUM_W-1:0] ADDR_ECFG   = 14'h4;
    localparam logic [CSR_NUM_W-1:0] ADDR_ESTAT  = 14'h5;
    localparam logic [CSR_NUM_W-1:0] ADDR_ERA    = 14'h6;
    localparam logic [CSR_NUM_W-1:0] ADDR_BADV   = 14'h7;
    localparam logic [CSR_NUM_W-1:0] ADDR_EENTRY = 14'hc;
    localparam logic [CSR_NUM_W-1:0] ADDR_SAVE0  = 14'h30; // save1..3 follow
    localparam logic [CSR_NUM_W-1:0] ADDR_TID    = 14'h40;
    localparam logic [CSR_NUM_W-1:0] ADDR_TCFG   = 14'h41;
    localparam logic [CSR_NUM_W-1:0] ADDR_TVAL   = 14'h42;
    localparam logic [CSR_NUM_W-1:0] ADDR_TICLR  = 14'h44;

    // da=1, plv=0, ie=0
    localparam logic [8:0] CRMD_RESET = 9'h8;

    localparam int TI_BIT       = 11; // timer bit in estat and ecfg
    localparam int EENTRY_ALIGN = 6;

    typedef enum logic [2:0] {
        op_none,
        op_rd,
        op_wr,
        op_xchg,
        op_ertn,
        op_excp
    } csr_op_e;

    typedef enum logic [5:0] {
        ec_int = 6'h0,
        ec_pil = 6'h1,
        ec_ade = 6'h8,
        ec_ale = 6'h9,
        ec_sys = 6'hb,
        ec_brk = 6'hc,
        ec_ine = 6'hd
    } ecode_e;

endpackage

//--- hw/csr_issue.sv
`timescale 1ns/1ns

module csr_issue (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              stall,
    input  logic                              flush,
    input  logic                              req_valid,
    input  csr_pkg::csr_op_e                  req_op,
    input  logic [csr_pkg::CSR_NUM_W-1:0]     csr_num,
    input  logic [csr_pkg::XLEN-1:0]          wdata,
    input  logic [csr_pkg::XLEN-1:0]          wmask,
    input  logic [csr_pkg::XLEN-1:0]          pc,
    input  logic [csr_pkg::XLEN-1:0]          badv_in,
    input  csr_pkg::ecode_e                   excp_ecode,
    input  logic [csr_pkg::SUBCODE_W-1:0]     excp_subcode,
    input  logic                              int_pending,
    output logic [csr_pkg::CSR_NUM_W-1:0]     rd_num,
    input  logic [csr_pkg::XLEN-1:0]          rd_data,
    output logic [csr_pkg::XLEN-1:0]          rdata,
    output logic                              stage_valid,
    output csr_pkg::csr_op_e                  stage_op,
    output logic [csr_pkg::CSR_NUM_W-1:0]     stage_num,
    output logic [csr_pkg::XLEN-1:0]          stage_wdata,
    output logic [csr_pkg::XLEN-1:0]          stage_pc,
    output logic [csr_pkg::XLEN-1:0]          stage_badv,
    output csr_pkg::ecode_e                   stage_ecode,
    output logic [csr_pkg::SUBCODE_W-1:0]     stage_subcode
);

    logic                         int_take;
    logic                         keep;
    csr_pkg::csr_op_e             op_eff;
    csr_pkg::ecode_e              ecode_eff;
    logic [csr_pkg::XLEN-1:0]     mask;
    logic [csr_pkg::XLEN-1:0]     merged;

    assign rd_num = csr_num;

    // any valid request is hijacked by a pending interrupt
    assign int_take = req_valid && int_pending;
    assign op_eff = int_take ? csr_pkg::op_excp : req_op;
    assign ecode_eff = int_take ? csr_pkg::ec_int : excp_ecode;

    // flushed requests die here, interrupts survive the flush
    assign keep = req_valid && (op_eff != csr_pkg::op_none) && (!flush || int_take);

    assign mask = (req_op == csr_pkg::op_wr) ? '1 : wmask;
    assign merged = (rd_data & ~mask) | (wdata & mask);

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            stage_valid <= 1'b0;
            stage_op <= csr_pkg::op_none;
            rdata <= '0;
        end
        else if (!stall)
        begin
            stage_valid <= keep;
            stage_op <= op_eff;
            if (req_valid)
                rdata <= rd_data; // old value, held until next accept
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            stage_num <= csr_num;
            stage_wdata <= merged;
            stage_pc <= pc;
            stage_ecode <= ecode_eff;
            stage_subcode <= int_take ? '0 : excp_subcode;
            stage_badv <= int_take ? pc : badv_in;
        end
    end

    a_stage_op_set: assert property (
        @(posedge clk) disable iff (!rstn)
        stage_valid |-> stage_op != csr_pkg::op_none
    );

endmodule

//--- hw/csr_regfile.sv
`timescale 1ns/1ns

module csr_regfile (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic [csr_pkg::CSR_NUM_W-1:0]     rd_num,
    output logic [csr_pkg::XLEN-1:0]          rd_data,
    input  logic                              wr_en,
    input  logic [csr_pkg::CSR_NUM_W-1:0]     wr_num,
    input  logic [csr_pkg::XLEN-1:0]          wr_data,
    input  logic                              excp_enter,
    input  csr_pkg::ecode_e                   excp_ecode,
    input  logic [csr_pkg::SUBCODE_W-1:0]     excp_subcode,
    input  logic [csr_pkg::XLEN-1:0]          excp_pc,
    input  logic [csr_pkg::XLEN-1:0]          excp_badv,
    input  logic                              ertn_exit,
    input  logic [csr_pkg::HWI_N-1:0]         hw_int,
    input  logic                              ti,
    input  logic [csr_pkg::XLEN-1:0]          tcfg,
    input  logic [csr_pkg::XLEN-1:0]          tval,
    output logic                              int_pending,
    output logic [csr_pkg::XLEN-1:0]          eentry,
    output logic [csr_pkg::XLEN-1:0]          era,
    output logic [1:0]                        crmd_plv,
    output logic                              crmd_ie
);

    logic [8:0]                                crmd;
    logic [2:0]                                prmd;
    logic [csr_pkg::TI_BIT:0]                  ecfg;
    logic [1:0]                                estat_is; // software interrupt bits
    csr_pkg::ecode_e                           estat_ecode;
    logic [csr_pkg::SUBCODE_W-1:0]             estat_subcode;
    logic [csr_pkg::XLEN-1:0]                  estat;
    logic [csr_pkg::XLEN-1:0]                  badv;
    logic [csr_pkg::XLEN-1:csr_pkg::EENTRY_ALIGN] eentry_hi;
    logic [csr_pkg::XLEN-1:0]                  save0, save1, save2, save3;
    logic [csr_pkg::XLEN-1:0]                  tid;

    always_comb
    begin
        estat = '0;
        estat[1:0] = estat_is;
        estat[2 +: csr_pkg::HWI_N] = hw_int;
        estat[csr_pkg::TI_BIT] = ti;
        estat[21:16] = estat_ecode;
        estat[30:22] = estat_subcode;
    end

    assign eentry = {eentry_hi, {csr_pkg::EENTRY_ALIGN{1'b0}}};
    assign crmd_plv = crmd[1:0];
    assign crmd_ie = crmd[2];
    assign int_pending = |(estat[csr_pkg::TI_BIT:0] & ecfg) & crmd_ie;

    always_comb
    begin
        rd_data = '0; // unknown numbers read as zero
        case (rd_num)
            csr_pkg::ADDR_CRMD:           rd_data = {23'b0, crmd};
            csr_pkg::ADDR_PRMD:           rd_data = {29'b0, prmd};
            csr_pkg::ADDR_ECFG:           rd_data = {20'b0, ecfg};
            csr_pkg::ADDR_ESTAT:          rd_data = estat;
            csr_pkg::ADDR_ERA:            rd_data = era;
            csr_pkg::ADDR_BADV:           rd_data = badv;
            csr_pkg::ADDR_EENTRY:         rd_data = eentry;
            csr_pkg::ADDR_SAVE0:          rd_data = save0;
            csr_pkg::ADDR_SAVE0 + 14'd1:  rd_data = save1;
            csr_pkg::ADDR_SAVE0 + 14'd2:  rd_data = save2;
            csr_pkg::ADDR_SAVE0 + 14'd3:  rd_data = save3;
            csr_pkg::ADDR_TID:            rd_data = tid;
            csr_pkg::ADDR_TCFG:           rd_data = tcfg;
            csr_pkg::ADDR_TVAL:           rd_data = tval;
            default:                      rd_data = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd <= csr_pkg::CRMD_RESET;
            prmd <= '0;
            ecfg <= '0;
            estat_is <= '0;
            estat_ecode <= csr_pkg::ec_int;
            estat_subcode <= '0;
            era <= '0;
            badv <= '0;
            eentry_hi <= '0;
            save0 <= '0;
            save1 <= '0;
            save2 <= '0;
            save3 <= '0;
            tid <= '0;
        end
        else if (excp_enter)
        begin
            prmd <= crmd[2:0];
            crmd[2:0] <= 3'b0; // plv0, interrupts off
            era <= excp_pc;
            estat_ecode <= excp_ecode;
            estat_subcode <= excp_subcode;
            if (excp_ecode == csr_pkg::ec_ale || excp_ecode == csr_pkg::ec_ade
                || excp_ecode == csr_pkg::ec_pil)
                badv <= excp_badv;
        end
        else if (ertn_exit)
        begin
            crmd[2:0] <= prmd;
        end
        else if (wr_en)
        begin
            case (wr_num)
                csr_pkg::ADDR_CRMD:           crmd <= wr_data[8:0];
                csr_pkg::ADDR_PRMD:           prmd <= wr_data[2:0];
                csr_pkg::ADDR_ECFG:           ecfg <= {wr_data[11], 1'b0, wr_data[9:0]};
                csr_pkg::ADDR_ESTAT:          estat_is <= wr_data[1:0];
                csr_pkg::ADDR_ERA:            era <= wr_data;
                csr_pkg::ADDR_BADV:           badv <= wr_data;
                csr_pkg::ADDR_EENTRY:         eentry_hi <= wr_data[31:csr_pkg::EENTRY_ALIGN];
                csr_pkg::ADDR_SAVE0:          save0 <= wr_data;
                csr_pkg::ADDR_SAVE0 + 14'd1:  save1 <= wr_data;
                csr_pkg::ADDR_SAVE0 + 14'd2:  save2 <= wr_data;
                csr_pkg::ADDR_SAVE0 + 14'd3:  save3 <= wr_data;
                csr_pkg::ADDR_TID:            tid <= wr_data;
                default:                      ;
            endcase
        end
    end

    a_no_wr_in_excp: assert property (
        @(posedge clk) disable iff (!rstn)
        !(excp_enter && wr_en)
    );

endmodule

//--- hw/csr_timer.sv
`timescale 1ns/1ns

module csr_timer (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              wr_en,
    input  logic [csr_pkg::CSR_NUM_W-1:0]     wr_num,
    input  logic [csr_pkg::XLEN-1:0]          wr_data,
    output logic                              ti,
    output logic [csr_pkg::XLEN-1:0]          tcfg,
    output logic [csr_pkg::XLEN-1:0]          tval
);

    logic tcfg_wr;
    logic ticlr_wr;

    assign tcfg_wr = wr_en && (wr_num == csr_pkg::ADDR_TCFG);
    assign ticlr_wr = wr_en && (wr_num == csr_pkg::ADDR_TICLR) && wr_data[0];

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg <= '0;
            tval <= '0;
            ti <= 1'b0;
        end
        else
        begin
            if (tcfg_wr)
            begin
                tcfg <= wr_data;
                if (wr_data[0])
                    tval <= {wr_data[31:2], 2'b00};
            end
            else if (tcfg[0])
            begin
                if (tval != '0)
                    tval <= tval - 1'b1;
                else if (tcfg[1])
                    tval <= {tcfg[31:2], 2'b00}; // periodic reload
            end

            if (ticlr_wr)
                ti <= 1'b0;
            else if (tcfg[0] && !tcfg_wr && tval == 32'd1)
                ti <= 1'b1; // rises as tval reaches zero
        end
    end

    a_tval_idle: assert property (
        @(posedge clk) disable iff (!rstn)
        (!tcfg[0] && !tcfg_wr) |=> $stable(tval)
    );

endmodule

//--- hw/csr_commit.sv
`timescale 1ns/1ns

module csr_commit (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              stall,
    input  logic                              stage_valid,
    input  csr_pkg::csr_op_e                  stage_op,
    input  logic [csr_pkg::CSR_NUM_W-1:0]     stage_num,
    input  logic [csr_pkg::XLEN-1:0]          stage_wdata,
    input  logic [csr_pkg::XLEN-1:0]          stage_pc,
    input  csr_pkg::ecode_e                   stage_ecode,
    input  logic [csr_pkg::SUBCODE_W-1:0]     stage_subcode,
    input  logic [csr_pkg::XLEN-1:0]          stage_badv,
    input  logic [csr_pkg::XLEN-1:0]          eentry,
    input  logic [csr_pkg::XLEN-1:0]          era,
    output logic                              wr_en,
    output logic [csr_pkg::CSR_NUM_W-1:0]     wr_num,
    output logic [csr_pkg::XLEN-1:0]          wr_data,
    output logic                              excp_enter,
    output logic                              ertn_exit,
    output logic                              redirect,
    output logic [csr_pkg::XLEN-1:0]          redirect_pc,
    output logic                              excp_flush,
    output logic                              ertn_flush
);

    logic commit;

    assign commit = stage_valid && !stall;
    assign wr_en = commit && (stage_op == csr_pkg::op_wr || stage_op == csr_pkg::op_xchg);
    assign wr_num = stage_num;
    assign wr_data = stage_wdata;
    assign excp_enter = commit && (stage_op == csr_pkg::op_excp);
    assign ertn_exit = commit && (stage_op == csr_pkg::op_ertn);

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            redirect <= 1'b0;
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
        end
        else
        begin
            excp_flush <= excp_enter; // single-cycle pulses
            ertn_flush <= ertn_exit;
            if (!stall)
                redirect <= commit && (stage_op != csr_pkg::op_rd);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            case (stage_op)
                csr_pkg::op_ertn: redirect_pc <= era;
                csr_pkg::op_excp: redirect_pc <= eentry;
                default:          redirect_pc <= stage_pc + 32'd4;
            endcase
        end
    end

    a_flush_excl: assert property (
        @(posedge clk) disable iff (!rstn)
        !(excp_flush && ertn_flush)
    );

    // interrupts come out of issue with no subcode and the pc as bad address
    a_int_clean: assert property (
        @(posedge clk) disable iff (!rstn)
        (excp_enter && stage_ecode == csr_pkg::ec_int)
            |-> (stage_subcode == '0 && stage_badv == stage_pc)
    );

endmodule

//--- hw/csr_unit.sv
`timescale 1ns/1ns

module csr_unit (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              req_valid,
    input  csr_pkg::csr_op_e                  req_op,
    input  logic [csr_pkg::CSR_NUM_W-1:0]     csr_num,
    input  logic [csr_pkg::XLEN-1:0]          wdata,
    input  logic [csr_pkg::XLEN-1:0]          wmask,
    input  logic [csr_pkg::XLEN-1:0]          pc,
    input  csr_pkg::ecode_e                   excp_ecode,
    input  logic [csr_pkg::SUBCODE_W-1:0]     excp_subcode,
    input  logic [csr_pkg::XLEN-1:0]          badv_in,
    input  logic [csr_pkg::HWI_N-1:0]         hw_int,
    input  logic                              stall,
    input  logic                              flush,
    output logic [csr_pkg::XLEN-1:0]          rdata,
    output logic                              redirect,
    output logic [csr_pkg::XLEN-1:0]          redirect_pc,
    output logic                              excp_flush,
    output logic                              ertn_flush,
    output logic [1:0]                        crmd_plv,
    output logic                              crmd_ie
);

    logic [csr_pkg::CSR_NUM_W-1:0]     rd_num;
    logic [csr_pkg::XLEN-1:0]          rd_data;
    logic                              int_pending;
    logic                              stage_valid;
    csr_pkg::csr_op_e                  stage_op;
    logic [csr_pkg::CSR_NUM_W-1:0]     stage_num;
    logic [csr_pkg::XLEN-1:0]          stage_wdata;
    logic [csr_pkg::XLEN-1:0]          stage_pc;
    logic [csr_pkg::XLEN-1:0]          stage_badv;
    csr_pkg::ecode_e                   stage_ecode;
    logic [csr_pkg::SUBCODE_W-1:0]     stage_subcode;
    logic                              wr_en;
    logic [csr_pkg::CSR_NUM_W-1:0]     wr_num;
    logic [csr_pkg::XLEN-1:0]          wr_data;
    logic                              excp_enter;
    logic                              ertn_exit;
    logic [csr_pkg::XLEN-1:0]          eentry;
    logic [csr_pkg::XLEN-1:0]          era;
    logic                              ti;
    logic [csr_pkg::XLEN-1:0]          tcfg;
    logic [csr_pkg::XLEN-1:0]          tval;

    csr_issue i_csr_issue (
        .clk(clk), .rstn(rstn), .stall(stall), .flush(flush),
        .req_valid(req_valid), .req_op(req_op), .csr_num(csr_num),
        .wdata(wdata), .wmask(wmask), .pc(pc), .badv_in(badv_in),
        .excp_ecode(excp_ecode), .excp_subcode(excp_subcode),
        .int_pending(int_pending), .rd_num(rd_num), .rd_data(rd_data), .rdata(rdata),
        .stage_valid(stage_valid), .stage_op(stage_op), .stage_num(stage_num),
        .stage_wdata(stage_wdata), .stage_pc(stage_pc), .stage_badv(stage_badv),
        .stage_ecode(stage_ecode), .stage_subcode(stage_subcode)
    );

    // exception fields go straight from the stage to the register file
    csr_regfile i_csr_regfile (
        .clk(clk), .rstn(rstn), .rd_num(rd_num), .rd_data(rd_data),
        .wr_en(wr_en), .wr_num(wr_num), .wr_data(wr_data),
        .excp_enter(excp_enter), .excp_ecode(stage_ecode), .excp_subcode(stage_subcode),
        .excp_pc(stage_pc), .excp_badv(stage_badv), .ertn_exit(ertn_exit),
        .hw_int(hw_int), .ti(ti), .tcfg(tcfg), .tval(tval),
        .int_pending(int_pending), .eentry(eentry), .era(era),
        .crmd_plv(crmd_plv), .crmd_ie(crmd_ie)
    );

    csr_timer i_csr_timer (
        .clk(clk), .rstn(rstn), .wr_en(wr_en), .wr_num(wr_num), .wr_data(wr_data),
        .ti(ti), .tcfg(tcfg), .tval(tval)
    );

    csr_commit i_csr_commit (
        .clk(clk), .rstn(rstn), .stall(stall),
        .stage_valid(stage_valid), .stage_op(stage_op), .stage_num(stage_num),
        .stage_wdata(stage_wdata), .stage_pc(stage_pc), .stage_ecode(stage_ecode),
        .stage_subcode(stage_subcode), .stage_badv(stage_badv),
        .eentry(eentry), .era(era),
        .wr_en(wr_en), .wr_num(wr_num), .wr_data(wr_data),
        .excp_enter(excp_enter), .ertn_exit(ertn_exit),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .excp_flush(excp_flush), .ertn_flush(ertn_flush)
    );

endmodule

//--- bench/csr_unit_tb.sv
`timescale 1ns/1ns

module csr_unit_tb;

    logic                              clk = 1'b0;
    logic                              rstn;
    logic                              req_valid;
    csr_pkg::csr_op_e                  req_op;
    logic [csr_pkg::CSR_NUM_W-1:0]     csr_num;
    logic [csr_pkg::XLEN-1:0]          wdata, wmask, pc, badv_in;
    csr_pkg::ecode_e                   excp_ecode;
    logic [csr_pkg::SUBCODE_W-1:0]     excp_subcode;
    logic [csr_pkg::HWI_N-1:0]         hw_int;
    logic                              stall, flush;
    logic [csr_pkg::XLEN-1:0]          rdata, redirect_pc;
    logic                              redirect, excp_flush, ertn_flush;
    logic [1:0]                        crmd_plv;
    logic                              crmd_ie;

    int    errors = 0;
    int    checks = 0;
    int    cycles = 0;
    int    limit = 200;
    string lines[$];

    csr_unit i_csr_unit (.*);

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= limit)
        begin
            $display("timeout: tests still running after %0d cycles", limit);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", name, what, exp, act);
        end
    endtask

    task automatic drive_req(input csr_pkg::csr_op_e op, input logic [13:0] num,
                             input logic [31:0] wd, input logic [31:0] wm,
                             input logic [31:0] addr, input logic [5:0] ec, input logic fl);
        req_valid = 1'b1;
        req_op = op;
        csr_num = num;
        wdata = wd;
        wmask = wm;
        pc = addr;
        badv_in = wd; // bad address rides in the wdata column
        excp_ecode = csr_pkg::ecode_e'(ec);
        flush = fl;
    endtask

    task automatic drive_idle();
        req_valid = 1'b0;
        req_op = csr_pkg::op_none;
        flush = 1'b0;
        stall = 1'b0;
    endtask

    // poll and irq go out as plain reads
    function automatic csr_pkg::csr_op_e op_code(input string s);
        if (s == "rd" || s == "poll" || s == "irq")
            return csr_pkg::op_rd;
        else if (s == "wr" || s == "stall")
            return csr_pkg::op_wr;
        else if (s == "xchg")
            return csr_pkg::op_xchg;
        else if (s == "ertn")
            return csr_pkg::op_ertn;
        else if (s == "excp")
            return csr_pkg::op_excp;
        return csr_pkg::op_none;
    endfunction

    initial
    begin
        int fd;
        int n;
        int fl;
        int tries;
        string line;
        string op_s;
        string name;
        logic [13:0] num;
        logic [5:0] ec;
        logic [31:0] wd, wm, addr, exp_rdata, exp_rpc, held_rdata;
        logic held_redirect;
        logic seen;
        logic exp_redir;
        logic exp_excp;
        logic exp_ertn;

        rstn = 1'b0;
        hw_int = '0;
        excp_subcode = '0;
        drive_req(csr_pkg::op_none, '0, '0, '0, '0, '0, 1'b0);
        drive_idle();

        fd = $fopen("bench/csr_tests.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("cannot open bench/csr_tests.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line.substr(0, 0) != "#")
                    lines.push_back(line);
            end
            $fclose(fd);
        end
        limit = lines.size() * 64 + 200;

        repeat (3) @(negedge clk);
        rstn = 1'b1;
        check_value("reset", "rdata", 32'd0, rdata);
        check_value("reset", "redirect and flushes", 32'd0,
                    32'(redirect | excp_flush | ertn_flush));
        held_rdata = '0;
        held_redirect = 1'b0;

        foreach (lines[k])
        begin
            n = $sscanf(lines[k], "%s %h %h %h %h %h %d %h %h %s",
                        op_s, num, wd, wm, addr, ec, fl, exp_rdata, exp_rpc, name);
            if (n != 10 || op_code(op_s) == csr_pkg::op_none)
            begin
                errors++;
                $display("test line %0d could not be parsed: %s", k + 1, lines[k]);
            end
            else if (op_s == "poll")
            begin
                seen = 1'b0;
                tries = 0;
                while (!seen && tries < 64)
                begin
                    drive_req(csr_pkg::op_rd, num, wd, wm, addr, ec, 1'b0);
                    @(negedge clk);
                    seen = rdata[csr_pkg::TI_BIT];
                    tries++;
                end
                drive_idle();
                checks++;
                assert (seen)
                else
                begin
                    errors++;
                    $display("%s: timer bit never showed up in %0d reads", name, tries);
                end
                check_value(name, "rdata", exp_rdata, rdata);
                held_rdata = exp_rdata;
                held_redirect = 1'b0; // reads never redirect
                @(negedge clk);
            end
            else
            begin
                drive_req(op_code(op_s), num, wd, wm, addr, ec, fl != 0);
                if (op_s == "stall")
                begin
                    stall = 1'b1;
                    repeat (4)
                    begin
                        @(negedge clk);
                        check_value(name, "rdata in stall", held_rdata, rdata);
                        check_value(name, "redirect in stall", 32'(held_redirect),
                                    32'(redirect));
                    end
                    stall = 1'b0; // request is accepted on the next edge
                end
                @(negedge clk);
                drive_idle();
                check_value(name, "rdata", exp_rdata, rdata);
                if (op_s == "rd" && num == csr_pkg::ADDR_CRMD)
                begin
                    check_value(name, "crmd_plv", 32'(exp_rdata[1:0]), 32'(crmd_plv));
                    check_value(name, "crmd_ie", 32'(exp_rdata[2]), 32'(crmd_ie));
                end
                @(negedge clk);
                exp_redir = (fl == 0) && (op_s != "rd");
                exp_excp = (op_s == "excp" || op_s == "irq");
                exp_ertn = (op_s == "ertn");
                check_value(name, "redirect", 32'(exp_redir), 32'(redirect));
                if (exp_redir)
                    check_value(name, "redirect_pc", exp_rpc, redirect_pc);
                check_value(name, "excp_flush", 32'(exp_excp), 32'(excp_flush));
                check_value(name, "ertn_flush", 32'(exp_ertn), 32'(ertn_flush));
                held_rdata = exp_rdata;
                held_redirect = exp_redir;
                if (exp_excp || exp_ertn)
                begin
                    @(negedge clk);
                    check_value(name, "flush pulse end", 32'd0, 32'(excp_flush | ertn_flush));
                    held_redirect = 1'b0; // idle commit after the pulse
                end
            end
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- bench/csr_tests.txt
# op csr_num wdata wmask pc ecode flush exp_rdata exp_redirect_pc name (hex except flush)
# excp carries badv in wdata; irq is a read that must be taken as an interrupt
rd    0000 00000000 00000000 1c000000 00 0 00000008 00000000 crmd_reset
rd    0030 00000000 00000000 1c000004 00 0 00000000 00000000 save0_reset
rd    000c 00000000 00000000 1c000008 00 0 00000000 00000000 eentry_reset
wr    000c 1c008000 00000000 1c000010 00 0 00000000 1c000014 eentry_wr
wr    0031 12345678 00000000 1c000020 00 0 00000000 1c000024 save1_wr
rd    0031 00000000 00000000 1c000028 00 0 12345678 00000000 save1_rd
xchg  0031 abcd0000 ffff0000 1c000030 00 0 12345678 1c000034 save1_xchg
rd    0031 00000000 00000000 1c000038 00 0 abcd5678 00000000 save1_merged
wr    0000 0000000d 00000000 1c000040 00 0 00000008 1c000044 crmd_wr
excp  0000 00001234 00000000 1c000050 09 0 0000000d 1c008000 ale_entry
rd    0006 00000000 00000000 1c000054 00 0 1c000050 00000000 era_rd
rd    0007 00000000 00000000 1c000058 00 0 00001234 00000000 badv_rd
rd    0005 00000000 00000000 1c00005c 00 0 00090000 00000000 estat_ale
rd    0001 00000000 00000000 1c000060 00 0 00000005 00000000 prmd_rd
rd    0000 00000000 00000000 1c000064 00 0 00000008 00000000 crmd_ie_off
ertn  0000 00000000 00000000 1c000068 00 0 00000008 1c000050 ertn_ret
rd    0000 00000000 00000000 1c00006c 00 0 0000000d 00000000 crmd_restored
wr    0032 55aa55aa 00000000 1c000070 00 1 00000000 00000000 save2_flushed
rd    0032 00000000 00000000 1c000074 00 0 00000000 00000000 save2_kept
wr    0000 00000008 00000000 1c000080 00 0 0000000d 1c000084 crmd_ie_clr
stall 0004 00000800 00000000 1c000090 00 0 00000000 1c000094 ecfg_stalled
wr    0041 00000011 00000000 1c0000a0 00 0 00000000 1c0000a4 tcfg_start
poll  0005 00000000 00000000 1c0000a8 00 0 00090800 00000000 estat_ti_poll
wr    0000 0000000c 00000000 1c0000b0 00 0 00000008 1c0000b4 crmd_ie_set
irq   0005 00000000 00000000 1c0000c0 00 0 00090800 1c008000 irq_taken
rd    0005 00000000 00000000 1c0000c4 00 0 00000800 00000000 estat_int
rd    0006 00000000 00000000 1c0000c8 00 0 1c0000c0 00000000 era_int
wr    0044 00000001 00000000 1c0000d0 00 0 00000000 1c0000d4 ticlr_wr
rd    0005 00000000 00000000 1c0000d8 00 0 00000000 00000000 estat_ti_clr

//--- sources.f
hw/csr_pkg.sv
hw/csr_issue.sv
hw/csr_regfile.sv
hw/csr_timer.sv
hw/csr_commit.sv
hw/csr_unit.sv
bench/csr_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module csr_unit_tb -f sources.f -o csr_unit_sim
out=$(./obj_dir/csr_unit_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TB PASSED"
